/* verilog/apple1_pkg.sv */
/*
 * Shared definitions for the Apple-1 memory fabric.
 * Holds the memory map, bus widths, the RAM bank table and the
 * reset hold length. Modules refer to these by scoped names.
 */
`default_nettype none

package apple1_pkg;

	// cpu bus widths
	localparam int ADDR_W = 16;
	localparam int DATA_W = 8;

	typedef logic [ADDR_W-1:0] addr_t;	// 6502 address
	typedef logic [DATA_W-1:0] data_t;	// one byte

	// 4 KiB ram banks
	localparam int BANK_ADDR_W = 12;
	localparam int BANK_PAGE_W = ADDR_W - BANK_ADDR_W;	// 4 bit page number
	localparam int NUM_BANKS = 5;

	// base page of each bank, entry 0 on the right
	// banks 0..3 cover 0x0000-0x3fff, bank 4 holds basic at 0xe000
	localparam logic [NUM_BANKS-1:0][BANK_PAGE_W-1:0] BANK_BASE = {
		4'hE,	// basic
		4'h3,
		4'h2,
		4'h1,
		4'h0
	};

	typedef logic [NUM_BANKS-1:0] bank_sel_t;	// one-hot or empty

	// wozmon page at 0xff00
	localparam int ROM_ADDR_W = 8;
	localparam logic [ADDR_W-ROM_ADDR_W-1:0] ROM_PAGE = 8'hFF;

	// core reset stretch
	localparam int RESET_HOLD = 16;	// cycles after the last cause
	localparam int HOLD_W = $clog2(RESET_HOLD + 1);
	typedef logic [HOLD_W-1:0] hold_cnt_t;
	localparam hold_cnt_t HOLD_LOAD = hold_cnt_t'(RESET_HOLD);

	// what the cpu sees outside the map
	localparam data_t UNMAPPED_DATA = 8'h00;

endpackage

`default_nettype wire

/* verilog/mem_bus_if.sv */
/*
 * One arbitrated memory access per cycle.
 * Driven by the arbiter, consumed by the ram banks, the monitor rom
 * and the read mux. valid marks a cycle that carries an access.
 */
`default_nettype none

interface mem_bus_if;

	logic                   valid;		// access in this cycle
	apple1_pkg::addr_t      addr;
	apple1_pkg::data_t      wdata;
	logic                   we;		// write to a ram bank
	apple1_pkg::bank_sel_t  bank_sel;	// one-hot bank decode
	logic                   rom_sel;	// 0xff00 page hit
	logic                   rom_we;		// download write into rom

	// decoder side
	modport arb (
		output valid, addr, wdata, we, bank_sel, rom_sel, rom_we
	);

	// memories
	modport mem (
		input addr, wdata, we, bank_sel, rom_we
	);

	// read data return path only needs the decode
	modport mux (
		input valid, bank_sel, rom_sel
	);

endinterface

`default_nettype wire

/* verilog/reset_ctrl.sv */
/*
 * Core reset conditioning.
 * Merges the system reset, the menu reset, the reset button and the
 * rising edge of the keyboard reset key, then stretches the result
 * for RESET_HOLD cycles after the last cause has gone.
 */
`default_nettype none

module reset_ctrl (
	input  wire  sys_clock,
	input  wire  reset,		// stands in for lost pll lock
	input  wire  menu_reset,
	input  wire  reset_button,
	input  wire  reset_key,
	output logic core_reset
);

	logic                   key_q;		// last sample of the key
	logic                   key_edge;
	logic                   cause;
	apple1_pkg::hold_cnt_t  hold_cnt;

	// only the press counts, a held key would lock the machine in reset
	assign key_edge = reset_key & ~key_q;
	assign cause = menu_reset | reset_button | key_edge;

	always_ff @(posedge sys_clock) begin
		if (reset) begin
			key_q    <= 1'b0;
			hold_cnt <= apple1_pkg::HOLD_LOAD;	// reset itself is a cause
		end else begin
			key_q <= reset_key;
			if (cause)
				hold_cnt <= apple1_pkg::HOLD_LOAD;	// reload on every cause
			else if (hold_cnt != '0)
				hold_cnt <= hold_cnt - 1'b1;
		end
	end

	// high while the counter runs
	assign core_reset = (hold_cnt != '0);

endmodule

`default_nettype wire

/* verilog/bus_arbiter.sv */
/*
 * Bus arbiter and address decoder.
 * A download write always wins over the cpu in the same cycle and the
 * cpu access is simply dropped. The chosen address is decoded into a
 * one-hot bank select or the monitor page. Purely combinational.
 */
`default_nettype none

module bus_arbiter (
	input  wire                cpu_clken,
	input  apple1_pkg::addr_t  cpu_addr,
	input  apple1_pkg::data_t  cpu_wdata,
	input  wire                cpu_we,
	input  wire                dl_active,
	input  wire                dl_wr,
	input  apple1_pkg::addr_t  dl_addr,
	input  apple1_pkg::data_t  dl_data,
	mem_bus_if.arb             bus,
	output logic               led
);

	logic                   dl_hit;		// download write this cycle
	logic                   access;
	logic                   wr;
	apple1_pkg::addr_t      addr;
	apple1_pkg::bank_sel_t  bank_hit;
	logic                   rom_hit;

	assign dl_hit = dl_active & dl_wr;
	assign access = dl_hit | cpu_clken;	// cpu only counts on its enable

	// source select, download first
	assign addr = dl_hit ? dl_addr : cpu_addr;
	assign wr   = dl_hit | cpu_we;

	// page compare against the bank table
	always_comb begin
		for (int i = 0; i < apple1_pkg::NUM_BANKS; i++) begin
			bank_hit[i] = access &&
				(addr[apple1_pkg::ADDR_W-1:apple1_pkg::BANK_ADDR_W] ==
				 apple1_pkg::BANK_BASE[i]);
		end
	end

	assign rom_hit = access &&
		(addr[apple1_pkg::ADDR_W-1:apple1_pkg::ROM_ADDR_W] == apple1_pkg::ROM_PAGE);

	assign bus.valid    = access;
	assign bus.addr     = addr;
	assign bus.wdata    = dl_hit ? dl_data : cpu_wdata;
	assign bus.bank_sel = bank_hit;
	assign bus.rom_sel  = rom_hit;
	assign bus.we       = wr & (|bank_hit);	// bank writes only
	assign bus.rom_we   = dl_hit & rom_hit;	// cpu cannot touch the rom

	// active low, lit while downloading bytes
	assign led = ~dl_hit;

endmodule

`default_nettype wire

/* verilog/ram_bank.sv */
/*
 * One 4 KiB synchronous ram bank.
 * INDEX picks the bank_sel bit this bank answers to. The read port
 * follows the bus address every cycle with one cycle of latency.
 */
`default_nettype none

module ram_bank #(
	parameter int INDEX = 0	// 0 .. NUM_BANKS-1
) (
	input  wire                sys_clock,
	mem_bus_if.mem             bus,
	output apple1_pkg::data_t  rdata
);

	localparam int DEPTH = 2 ** apple1_pkg::BANK_ADDR_W;

	apple1_pkg::data_t                    mem [DEPTH];
	logic [apple1_pkg::BANK_ADDR_W-1:0]   offset;
	logic                                 wr_en;

	assign offset = bus.addr[apple1_pkg::BANK_ADDR_W-1:0];	// low 12 bits
	assign wr_en  = bus.bank_sel[INDEX] & bus.we;

	// write port
	always_ff @(posedge sys_clock) begin
		if (wr_en)
			mem[offset] <= bus.wdata;
	end

	// read first, the mux decides whether anyone wanted it
	always_ff @(posedge sys_clock) begin
		rdata <= mem[offset];
	end

endmodule

`default_nettype wire

/* verilog/boot_rom.sv */
/*
 * 256 byte monitor page at 0xff00.
 * Loaded only by the download port, cpu writes never reach it.
 * Read data is registered every cycle.
 */
`default_nettype none

module boot_rom (
	input  wire                sys_clock,
	mem_bus_if.mem             bus,
	output apple1_pkg::data_t  rdata
);

	localparam int DEPTH = 2 ** apple1_pkg::ROM_ADDR_W;

	apple1_pkg::data_t                  rom [DEPTH];
	logic [apple1_pkg::ROM_ADDR_W-1:0]  offset;

	assign offset = bus.addr[apple1_pkg::ROM_ADDR_W-1:0];	// low byte

	always_ff @(posedge sys_clock) begin
		if (bus.rom_we)		// download only
			rom[offset] <= bus.wdata;
		rdata <= rom[offset];
	end

endmodule

`default_nettype wire

/* verilog/read_mux.sv */
/*
 * Read data return path.
 * Keeps the decode of each access for one cycle so that it lines up
 * with the registered memory outputs, then loads cpu_rdata with the
 * selected byte. Unmapped accesses return UNMAPPED_DATA and idle
 * cycles leave cpu_rdata alone.
 */
`default_nettype none

module read_mux (
	input  wire                sys_clock,
	input  wire                reset,
	mem_bus_if.mux             bus,
	input  apple1_pkg::data_t  bank_rdata [apple1_pkg::NUM_BANKS],
	input  apple1_pkg::data_t  rom_rdata,
	output apple1_pkg::data_t  cpu_rdata
);

	logic                   valid_q;	// access one cycle back
	apple1_pkg::bank_sel_t  bank_q;
	logic                   rom_q;
	apple1_pkg::data_t      pick;

	// decode aligned with memory read latency
	always_ff @(posedge sys_clock) begin
		if (reset) begin
			valid_q <= 1'b0;
			bank_q  <= '0;
			rom_q   <= 1'b0;
		end else begin
			valid_q <= bus.valid;
			if (bus.valid) begin
				bank_q <= bus.bank_sel;
				rom_q  <= bus.rom_sel;
			end
		end
	end

	// selects are one-hot or empty
	always_comb begin
		pick = apple1_pkg::UNMAPPED_DATA;
		for (int i = 0; i < apple1_pkg::NUM_BANKS; i++) begin
			if (bank_q[i])
				pick = bank_rdata[i];
		end
		if (rom_q)
			pick = rom_rdata;
	end

	always_ff @(posedge sys_clock) begin
		if (reset)
			cpu_rdata <= '0;
		else if (valid_q)
			cpu_rdata <= pick;	// hold otherwise
	end

endmodule

`default_nettype wire

/* verilog/apple1_mem_top.sv */
/*
 * Apple-1 memory fabric top level.
 * The cpu bus and the download write port come in as plain ports.
 * Reset conditioning, arbitration, four low ram banks, the basic
 * bank, the monitor page and the read mux are wired up here.
 * The reset input plays the part of a lost pll lock.
 */
`default_nettype none

module apple1_mem_top (
	input  wire                sys_clock,
	input  wire                reset,
	input  wire                menu_reset,
	input  wire                reset_button,
	input  wire                reset_key,
	input  wire                cpu_clken,
	input  apple1_pkg::addr_t  cpu_addr,
	input  apple1_pkg::data_t  cpu_wdata,
	input  wire                cpu_we,
	output apple1_pkg::data_t  cpu_rdata,
	input  wire                dl_active,
	input  wire                dl_wr,
	input  apple1_pkg::addr_t  dl_addr,
	input  apple1_pkg::data_t  dl_data,
	output logic               core_reset,
	output logic               led
);

	mem_bus_if bus ();

	apple1_pkg::data_t  bank_rdata [apple1_pkg::NUM_BANKS];
	apple1_pkg::data_t  rom_rdata;

	reset_ctrl u_reset_ctrl (
		.sys_clock    (sys_clock),
		.reset        (reset),
		.menu_reset   (menu_reset),
		.reset_button (reset_button),
		.reset_key    (reset_key),
		.core_reset   (core_reset)
	);

	bus_arbiter u_bus_arbiter (
		.cpu_clken (cpu_clken),
		.cpu_addr  (cpu_addr),
		.cpu_wdata (cpu_wdata),
		.cpu_we    (cpu_we),
		.dl_active (dl_active),
		.dl_wr     (dl_wr),
		.dl_addr   (dl_addr),
		.dl_data   (dl_data),
		.bus       (bus.arb),
		.led       (led)
	);

	// banks 0..3 low ram, last one basic
	for (genvar g = 0; g < apple1_pkg::NUM_BANKS; g++) begin : g_bank
		ram_bank #(
			.INDEX (g)
		) u_ram_bank (
			.sys_clock (sys_clock),
			.bus       (bus.mem),
			.rdata     (bank_rdata[g])
		);
	end

	boot_rom u_boot_rom (
		.sys_clock (sys_clock),
		.bus       (bus.mem),
		.rdata     (rom_rdata)
	);

	read_mux u_read_mux (
		.sys_clock  (sys_clock),
		.reset      (reset),
		.bus        (bus.mux),
		.bank_rdata (bank_rdata),
		.rom_rdata  (rom_rdata),
		.cpu_rdata  (cpu_rdata)
	);

endmodule

`default_nettype wire

/* tb/tb_vectors.svh */
/*
 * Stimulus table for the memory fabric testbench.
 * Included inside the testbench module. Rows run top to bottom, each
 * one access followed by idle cycles and a read data check.
 */
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

typedef enum logic [2:0] {
	OP_CPU_WR,	// cpu write, clken high
	OP_CPU_RD,	// cpu read, clken high
	OP_DL_WR,	// download write
	OP_COLLIDE,	// download and cpu write, same address
	OP_IDLE		// cpu write attempt with clken low
} op_t;

typedef struct packed {
	op_t                op;
	apple1_pkg::addr_t  addr;
	apple1_pkg::data_t  data;	// replaced by a random byte when rnd is set
	logic               rnd;
	int                 src;	// row whose data cpu_rdata should show, -1 uses exp
	apple1_pkg::data_t  exp;
	logic               chk;	// compare cpu_rdata
	logic               exp_led;	// led level during the access
} vec_t;

localparam int NUM_VEC = 34;

// op, addr, data, rnd, src, exp, chk, exp_led
vec_t vectors [NUM_VEC] = '{
	'{OP_CPU_WR,  16'h0010, 8'h00, 1'b1, -1, 8'h00, 1'b0, 1'b1},	// bank 0
	'{OP_CPU_WR,  16'h1123, 8'h00, 1'b1, -1, 8'h00, 1'b0, 1'b1},	// bank 1
	'{OP_CPU_WR,  16'h2040, 8'h00, 1'b1, -1, 8'h00, 1'b0, 1'b1},	// bank 2
	'{OP_CPU_WR,  16'h3FFF, 8'h00, 1'b1, -1, 8'h00, 1'b0, 1'b1},	// bank 3 top
	'{OP_CPU_WR,  16'hE000, 8'h00, 1'b1, -1, 8'h00, 1'b0, 1'b1},	// basic
	'{OP_CPU_WR,  16'hEFFF, 8'h00, 1'b1, -1, 8'h00, 1'b0, 1'b1},
	'{OP_CPU_RD,  16'h0010, 8'h00, 1'b0,  0, 8'h00, 1'b1, 1'b1},
	'{OP_CPU_RD,  16'h1123, 8'h00, 1'b0,  1, 8'h00, 1'b1, 1'b1},
	'{OP_CPU_RD,  16'h2040, 8'h00, 1'b0,  2, 8'h00, 1'b1, 1'b1},
	'{OP_CPU_RD,  16'h3FFF, 8'h00, 1'b0,  3, 8'h00, 1'b1, 1'b1},
	'{OP_CPU_RD,  16'hE000, 8'h00, 1'b0,  4, 8'h00, 1'b1, 1'b1},
	'{OP_CPU_RD,  16'hEFFF, 8'h00, 1'b0,  5, 8'h00, 1'b1, 1'b1},
	'{OP_DL_WR,   16'hFF00, 8'h00, 1'b1, -1, 8'h00, 1'b0, 1'b0},	// monitor page
	'{OP_DL_WR,   16'hFFFF, 8'h00, 1'b1, -1, 8'h00, 1'b0, 1'b0},
	'{OP_CPU_RD,  16'hFF00, 8'h00, 1'b0, 12, 8'h00, 1'b1, 1'b1},
	'{OP_CPU_RD,  16'hFFFF, 8'h00, 1'b0, 13, 8'h00, 1'b1, 1'b1},
	'{OP_CPU_WR,  16'hFF00, 8'h5A, 1'b0, -1, 8'h00, 1'b0, 1'b1},	// must not land
	'{OP_CPU_RD,  16'hFF00, 8'h00, 1'b0, 12, 8'h00, 1'b1, 1'b1},
	'{OP_CPU_RD,  16'h4000, 8'h00, 1'b0, -1, 8'h00, 1'b1, 1'b1},	// old sdram hole
	'{OP_CPU_RD,  16'h8123, 8'h00, 1'b0, -1, 8'h00, 1'b1, 1'b1},
	'{OP_CPU_RD,  16'hBFFF, 8'h00, 1'b0, -1, 8'h00, 1'b1, 1'b1},
	'{OP_CPU_RD,  16'hC000, 8'h00, 1'b0, -1, 8'h00, 1'b1, 1'b1},
	'{OP_CPU_RD,  16'hF000, 8'h00, 1'b0, -1, 8'h00, 1'b1, 1'b1},
	'{OP_CPU_WR,  16'h5123, 8'h00, 1'b1, -1, 8'h00, 1'b0, 1'b1},	// aliases 0x1123
	'{OP_CPU_RD,  16'h5123, 8'h00, 1'b0, -1, 8'h00, 1'b1, 1'b1},
	'{OP_CPU_RD,  16'h1123, 8'h00, 1'b0,  1, 8'h00, 1'b1, 1'b1},	// still old byte
	'{OP_COLLIDE, 16'h2040, 8'h00, 1'b1, -1, 8'h00, 1'b0, 1'b0},
	'{OP_CPU_RD,  16'h2040, 8'h00, 1'b0, 26, 8'h00, 1'b1, 1'b1},
	'{OP_COLLIDE, 16'hFF80, 8'h00, 1'b1, -1, 8'h00, 1'b0, 1'b0},
	'{OP_CPU_RD,  16'hFF80, 8'h00, 1'b0, 28, 8'h00, 1'b1, 1'b1},
	'{OP_IDLE,    16'h2040, 8'h00, 1'b1, 28, 8'h00, 1'b1, 1'b1},	// rdata held
	'{OP_CPU_RD,  16'h2040, 8'h00, 1'b0, 26, 8'h00, 1'b1, 1'b1},
	'{OP_IDLE,    16'h0010, 8'h00, 1'b1, 26, 8'h00, 1'b1, 1'b1},
	'{OP_CPU_RD,  16'h0010, 8'h00, 1'b0,  0, 8'h00, 1'b1, 1'b1}
};

`endif

/* tb/tb_apple1_mem.sv */
/*
 * Testbench for the Apple-1 memory fabric.
 * Checks the core reset stretch first, then applies the vector table:
 * bank and monitor page accesses with read back, unmapped reads,
 * collisions and idle cycles. Run it through run_sim.sh.
 */
`default_nettype none

module tb_apple1_mem;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int HALF_PERIOD = 10;	// 20 ns clock
	localparam int RESET_CYCLES = 8;
	localparam int RESET_TIMEOUT = 4 * apple1_pkg::RESET_HOLD;
	localparam logic [31:0] RAND_SEED = 32'h84a8_1333;

	`include "tb_vectors.svh"

	logic               sys_clock = 1'b0;
	logic               reset, menu_reset, reset_button, reset_key;
	logic               cpu_clken, cpu_we, dl_active, dl_wr;
	apple1_pkg::addr_t  cpu_addr, dl_addr;
	apple1_pkg::data_t  cpu_wdata, dl_data, cpu_rdata;
	logic               core_reset, led;

	int data_errors = 0;
	int flag_errors = 0;
	int other_errors = 0;
	logic timed_out = 1'b0;	// a wait gave up

	apple1_mem_top DUT (
		.sys_clock    (sys_clock),
		.reset        (reset),
		.menu_reset   (menu_reset),
		.reset_button (reset_button),
		.reset_key    (reset_key),
		.cpu_clken    (cpu_clken),
		.cpu_addr     (cpu_addr),
		.cpu_wdata    (cpu_wdata),
		.cpu_we       (cpu_we),
		.cpu_rdata    (cpu_rdata),
		.dl_active    (dl_active),
		.dl_wr        (dl_wr),
		.dl_addr      (dl_addr),
		.dl_data      (dl_data),
		.core_reset   (core_reset),
		.led          (led)
	);

	always #HALF_PERIOD sys_clock = ~sys_clock;

	task check_data(input string name, input apple1_pkg::data_t got,
			input apple1_pkg::data_t exp);
		if (got !== exp) begin
			data_errors++;
			$display("CHECK FAILED time=%0t signal=%s got=%h expected=%h",
				$time, name, got, exp);
		end
	endtask

	task check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			flag_errors++;
			$display("CHECK FAILED time=%0t signal=%s got=%b expected=%b",
				$time, name, got, exp);
		end
	endtask

	task report_counts();
		$display("errors: data %0d, flag %0d, other %0d",
			data_errors, flag_errors, other_errors);
	endtask

	// core_reset must stay high for hold cycles, then drop
	task wait_reset_fall(input int hold);
		int   cycles;
		logic fell;
		cycles = 0;
		fell = 1'b0;
		while (!fell && cycles < RESET_TIMEOUT) begin
			@(posedge sys_clock);
			cycles++;
			@(negedge sys_clock);
			check_flag("core_reset", core_reset, cycles < hold);
			fell = !core_reset;
		end
		if (!fell) begin
			other_errors++;
			timed_out = 1'b1;
			$display("ERROR at %0t: core_reset did not fall within the timeout",
				$time);
		end
	endtask

	// release, one key press, then a held key
	task exercise_reset();
		@(posedge sys_clock);
		reset <= 1'b0;	// last reset cycle
		wait_reset_fall(apple1_pkg::RESET_HOLD);
		if (timed_out)
			return;
		check_data("cpu_rdata", cpu_rdata, 8'h00);	// cleared by reset

		// single key press
		@(posedge sys_clock);
		reset_key <= 1'b1;
		@(posedge sys_clock);
		reset_key <= 1'b0;
		@(negedge sys_clock);
		check_flag("core_reset", core_reset, 1'b1);
		wait_reset_fall(apple1_pkg::RESET_HOLD);
		if (timed_out)
			return;

		// held key, one stretch only
		@(posedge sys_clock);
		reset_key <= 1'b1;
		wait_reset_fall(apple1_pkg::RESET_HOLD + 1);
		if (timed_out)
			return;
		repeat (2 * apple1_pkg::RESET_HOLD) begin
			@(negedge sys_clock);
			check_flag("core_reset", core_reset, 1'b0);
		end
		@(posedge sys_clock);
		reset_key <= 1'b0;
	endtask

	task drive_idle();
		cpu_clken <= 1'b0;
		cpu_we    <= 1'b0;
		dl_active <= 1'b0;
		dl_wr     <= 1'b0;
	endtask

	// one access, two idle edges, then the read data is due
	task apply_row(input vec_t v, input apple1_pkg::data_t exp_rdata);
		@(posedge sys_clock);
		case (v.op)
			OP_CPU_WR, OP_IDLE: begin
				cpu_clken <= (v.op == OP_CPU_WR);
				cpu_we    <= 1'b1;
				cpu_addr  <= v.addr;
				cpu_wdata <= v.data;
			end
			OP_CPU_RD: begin
				cpu_clken <= 1'b1;
				cpu_addr  <= v.addr;
			end
			OP_DL_WR, OP_COLLIDE: begin
				dl_active <= 1'b1;
				dl_wr     <= 1'b1;
				dl_addr   <= v.addr;
				dl_data   <= v.data;
				if (v.op == OP_COLLIDE) begin	// cpu tries another byte
					cpu_clken <= 1'b1;
					cpu_we    <= 1'b1;
					cpu_addr  <= v.addr;
					cpu_wdata <= ~v.data;
				end
			end
			default: ;
		endcase
		@(negedge sys_clock);
		check_flag("led", led, v.exp_led);
		@(posedge sys_clock);	// sampled here
		drive_idle();
		@(posedge sys_clock);	// rdata loads here
		@(negedge sys_clock);
		check_flag("led", led, 1'b1);
		if (v.chk)
			check_data("cpu_rdata", cpu_rdata, exp_rdata);
	endtask

	initial begin
		apple1_pkg::data_t expect_byte;
		reset        = 1'b1;
		menu_reset   = 1'b0;
		reset_button = 1'b0;
		reset_key    = 1'b0;
		cpu_clken    = 1'b0;
		cpu_we       = 1'b0;
		cpu_addr     = '0;
		cpu_wdata    = '0;
		dl_active    = 1'b0;
		dl_wr        = 1'b0;
		dl_addr      = '0;
		dl_data      = '0;
		void'($urandom(RAND_SEED));
		for (int i = 0; i < NUM_VEC; i++) begin
			if (vectors[i].rnd)
				vectors[i].data = apple1_pkg::data_t'($urandom);
		end

		repeat (RESET_CYCLES - 1) @(posedge sys_clock);
		@(negedge sys_clock);
		check_flag("core_reset", core_reset, 1'b1);
		exercise_reset();

		if (!timed_out) begin
			for (int i = 0; i < NUM_VEC; i++) begin
				if (vectors[i].src >= 0)
					expect_byte = vectors[vectors[i].src].data;
				else
					expect_byte = vectors[i].exp;
				apply_row(vectors[i], expect_byte);
			end
		end

		report_counts();
		if (data_errors + flag_errors + other_errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+tb
verilog/apple1_pkg.sv
verilog/mem_bus_if.sv
verilog/reset_ctrl.sv
verilog/bus_arbiter.sv
verilog/ram_bank.sv
verilog/boot_rom.sv
verilog/read_mux.sv
verilog/apple1_mem_top.sv
tb/tb_apple1_mem.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the memory fabric testbench with Verilator.
# Exit status is 0 only when the build and run succeed and the log
# holds no fail message.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing -f vlog.f --top-module tb_apple1_mem \
	--Mdir obj_dir -o tb_apple1_mem
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_apple1_mem > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "test failed" sim.log; then
	exit 1
fi
exit 0
